// File: logic/loadQueue.sv
// load queue entries, the two-stage load pipeline to write-back and the store-side violation search
`timescale 1ns/1ps

module loadQueue import lsuPkg::*; #(
	parameter int lsqDepth = LSQ_DEPTH
) (
	input  logic     clk,
	input  logic     reset,
	lsqPtrIf.queue   ptr,
	input  memPkt_t  memPkt_i,
	output addr_t    srchAddr_o,		// forwarding lookup into stq
	output lsqIdx_t  srchOlderTail_o,
	input  logic     fwdHit_i,
	input  data_t    fwdData_i,
	output logic     ldEn_o,			// memory read, T+1
	output addr_t    ldAddr_o,
	input  data_t    ldData_i,			// async read data, same cycle as ldEn_o
	output logic     wbValid_o,			// T+2
	output lsqIdx_t  wbLqId_o,
	output data_t    wbData_o,
	output logic     vioValid_o,		// store found an early load
	output lsqIdx_t  vioLqId_o
);

	logic [lsqDepth-1:0] ldValid;
	logic [lsqDepth-1:0] executed;		// load already went down the pipe
	addr_t               ldAddr [lsqDepth];
	lsqIdx_t             stqTailRec [lsqDepth];	// first younger store

	logic                ldPkt;
	logic                stPkt;
	logic [lsqDepth-1:0] vioMatch;
	logic                vioFound;
	lsqIdx_t             vioIdx;		// oldest violating load

	// stage 1 regs, T+1
	logic    s1Valid;
	lsqIdx_t s1LqId;
	addr_t   s1Addr;
	logic    s1FwdHit;
	data_t   s1FwdData;

	assign ldPkt = memPkt_i.valid & memPkt_i.isLoad;
	assign stPkt = memPkt_i.valid & ~memPkt_i.isLoad;

	assign srchAddr_o      = memPkt_i.addr;
	assign srchOlderTail_o = stqTailRec[memPkt_i.lsqId];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ldValid  <= '0;
			executed <= '0;
		end
		else if (ptr.recover)
		begin
			ldValid  <= '0;
			executed <= '0;
		end
		else
		begin
			if (ptr.commitLd)
				ldValid[ptr.ldqHead] <= 1'b0;
			if (ptr.dispLoad)
			begin
				ldValid[ptr.ldqTail]  <= 1'b1;
				executed[ptr.ldqTail] <= 1'b0;
			end
			if (ldPkt)
				executed[memPkt_i.lsqId] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ptr.dispLoad)
			stqTailRec[ptr.ldqTail] <= ptr.stqTail;	// marks older stores
		if (ldPkt)
			ldAddr[memPkt_i.lsqId] <= memPkt_i.addr;
	end

	// load pipe, valids squashed by recovery
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1Valid   <= 1'b0;
			wbValid_o <= 1'b0;
		end
		else
		begin
			s1Valid   <= ldPkt & ~ptr.recover;
			wbValid_o <= s1Valid & ~ptr.recover;
		end
	end

	always_ff @(posedge clk)
	begin
		s1LqId    <= memPkt_i.lsqId;
		s1Addr    <= memPkt_i.addr;
		s1FwdHit  <= fwdHit_i;
		s1FwdData <= fwdData_i;
		wbLqId_o  <= s1LqId;
		wbData_o  <= s1FwdHit ? s1FwdData : ldData_i;	// stq beats memory
	end

	assign ldEn_o   = s1Valid;
	assign ldAddr_o = s1Addr;

	// store is older than a load when it sits before that load's recorded tail
	always_comb
	begin
		for (int i = 0; i < lsqDepth; i++)
			vioMatch[i] = ldValid[i] & executed[i] & (ldAddr[i] == memPkt_i.addr) &&
				(ringDist(ptr.stqHead, memPkt_i.lsqId, lsqDepth) <
				 ringDist(ptr.stqHead, stqTailRec[i], lsqDepth));
	end

	// oldest match, closest to ldq head
	always_comb
	begin
		vioFound = 1'b0;
		vioIdx   = '0;
		for (int i = 0; i < lsqDepth; i++)
		begin
			if (vioMatch[i] && (!vioFound ||
				ringDist(ptr.ldqHead, lsqIdx_t'(i), lsqDepth) <
				ringDist(ptr.ldqHead, vioIdx, lsqDepth)))
			begin
				vioFound = 1'b1;
				vioIdx   = lsqIdx_t'(i);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			vioValid_o <= 1'b0;
		else
			vioValid_o <= stPkt & vioFound & ~ptr.recover;
	end

	always_ff @(posedge clk)
	begin
		vioLqId_o <= vioIdx;
	end

endmodule

// File: logic/lsqControl.sv
// head, tail and count bookkeeping for the load and store queues; hands out the queue index at dispatch
`timescale 1ns/1ps

module lsqControl import lsuPkg::*; #(
	parameter int lsqDepth = LSQ_DEPTH
) (
	input  logic       clk,
	input  logic       reset,
	input  logic       lsqValid_i,		// instruction at dispatch is a load or store
	input  logic       lsqIsLoad_i,
	input  logic       dispatchReady_i,	// backend has room for it
	input  logic       commitLoad_i,
	input  logic       commitStore_i,
	input  logic       recoverFlag_i,
	output lsqIdx_t    lsqId_o,			// entry given to the dispatched op
	output lsqCnt_t    ldqCount_o,
	output lsqCnt_t    stqCount_o,
	lsqPtrIf.ctrl      ptr
);

	logic    accept;		// dispatch taken this cycle
	logic    dispLd;
	logic    dispSt;
	lsqIdx_t ldqHead;
	lsqIdx_t ldqTail;
	lsqIdx_t stqHead;
	lsqIdx_t stqTail;
	lsqIdx_t ldqHeadNext;	// head after this cycle's commit
	lsqIdx_t stqHeadNext;
	lsqCnt_t ldqCount;
	lsqCnt_t stqCount;

	// step one entry, wrapping at the configured depth
	function automatic lsqIdx_t incPtr(lsqIdx_t p);
		return (p == lsqIdx_t'(lsqDepth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign accept = lsqValid_i & dispatchReady_i;
	assign dispLd = accept & lsqIsLoad_i;
	assign dispSt = accept & ~lsqIsLoad_i;

	assign lsqId_o = lsqIsLoad_i ? ldqTail : stqTail;	// same cycle as dispatch

	assign ldqHeadNext = commitLoad_i  ? incPtr(ldqHead) : ldqHead;
	assign stqHeadNext = commitStore_i ? incPtr(stqHead) : stqHead;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ldqHead  <= '0;
			ldqTail  <= '0;
			stqHead  <= '0;
			stqTail  <= '0;
			ldqCount <= '0;
			stqCount <= '0;
		end
		else if (recoverFlag_i)
		begin
			// commits this cycle still retire, everything past them is dropped
			ldqHead  <= ldqHeadNext;
			stqHead  <= stqHeadNext;
			ldqTail  <= ldqHeadNext;	// empty ring, tail sits on head
			stqTail  <= stqHeadNext;
			ldqCount <= '0;
			stqCount <= '0;
		end
		else
		begin
			ldqHead <= ldqHeadNext;
			stqHead <= stqHeadNext;
			if (dispLd)
				ldqTail <= incPtr(ldqTail);
			if (dispSt)
				stqTail <= incPtr(stqTail);
			// upstream never overfills or commits from empty
			ldqCount <= ldqCount + lsqCnt_t'(dispLd) - lsqCnt_t'(commitLoad_i);
			stqCount <= stqCount + lsqCnt_t'(dispSt) - lsqCnt_t'(commitStore_i);
		end
	end

	assign ldqCount_o = ldqCount;
	assign stqCount_o = stqCount;

	// broadcast to both queues
	assign ptr.ldqHead   = ldqHead;
	assign ptr.ldqTail   = ldqTail;
	assign ptr.stqHead   = stqHead;
	assign ptr.stqTail   = stqTail;
	assign ptr.dispLoad  = dispLd;
	assign ptr.dispStore = dispSt;
	assign ptr.commitLd  = commitLoad_i;
	assign ptr.commitSt  = commitStore_i;
	assign ptr.recover   = recoverFlag_i;

endmodule

// File: logic/lsqPtrIf.sv
// queue pointers plus dispatch, commit and recovery strobes, driven by lsqControl and read by both queues
`timescale 1ns/1ps

interface lsqPtrIf import lsuPkg::*; ();

	lsqIdx_t ldqHead;	// oldest load
	lsqIdx_t ldqTail;	// next free load entry
	lsqIdx_t stqHead;	// oldest store, next to commit
	lsqIdx_t stqTail;	// next free store entry

	logic dispLoad;		// accepted load dispatch, takes ldqTail
	logic dispStore;	// accepted store dispatch, takes stqTail
	logic commitLd;		// frees ldqHead at the edge
	logic commitSt;		// writes stqHead to memory
	logic recover;		// flush both queues

	// control side drives everything
	modport ctrl (
		output ldqHead, ldqTail, stqHead, stqTail,
		output dispLoad, dispStore, commitLd, commitSt, recover
	);

	// queues only look
	modport queue (
		input ldqHead, ldqTail, stqHead, stqTail,
		input dispLoad, dispStore, commitLd, commitSt, recover
	);

endinterface

// File: logic/lsuPkg.sv
// shared widths, index and count types and the agen packet for the load-store unit; import with lsuPkg::*
package lsuPkg;

	// queue geometry
	localparam int LSQ_DEPTH = 8;	// default entries per queue, top level may override
	localparam int LSQ_IDX_W = 3;	// index bits for one queue
	localparam int ADDR_W    = 16;	// word address, no byte offset
	localparam int DATA_W    = 32;	// whole words only

	typedef logic [LSQ_IDX_W-1:0] lsqIdx_t;	// entry index into ldq or stq
	typedef logic [LSQ_IDX_W:0]   lsqCnt_t;	// occupancy, 0 .. depth
	typedef logic [ADDR_W-1:0]    addr_t;
	typedef logic [DATA_W-1:0]    data_t;

	// packet from address generation, one per cycle, load or store
	typedef struct packed
	{
		logic    valid;		// packet present this cycle
		logic    isLoad;	// 1 load, 0 store
		lsqIdx_t lsqId;		// entry in ldq or stq given at dispatch
		addr_t   addr;		// word address
		data_t   data;		// store data, ignored for loads
	} memPkt_t;			// 53 bits

	// distance from one pointer to another walking forward round the ring
	// used for program-order compares in both queues
	function automatic int ringDist(lsqIdx_t fromIdx, lsqIdx_t toIdx, int depth);
		return (int'(toIdx) - int'(fromIdx) + depth) % depth;
	endfunction

	// note: equal pointers give distance 0, so a window from head to a tail
	// that sits on head reads as empty

endpackage

// File: logic/lsuTop.sv
// load-store unit top level with plain ports; joins the control block and both queues
`timescale 1ns/1ps

module lsuTop import lsuPkg::*; #(
	parameter int lsqDepth = LSQ_DEPTH
) (
	input  logic    clk,
	input  logic    reset,
	// dispatch
	input  logic    lsqValid_i,
	input  logic    lsqIsLoad_i,
	input  logic    dispatchReady_i,
	output lsqIdx_t lsqId_o,
	output lsqCnt_t ldqCount_o,
	output lsqCnt_t stqCount_o,
	// commit and flush
	input  logic    commitLoad_i,
	input  logic    commitStore_i,
	input  logic    recoverFlag_i,
	// agen
	input  logic    memValid_i,
	input  logic    memIsLoad_i,
	input  lsqIdx_t memLsqId_i,
	input  addr_t   memAddr_i,
	input  data_t   memData_i,
	// memory read
	output logic    ldEn_o,
	output addr_t   ldAddr_o,
	input  data_t   ldData_i,
	// memory write
	output logic    stEn_o,
	output addr_t   stAddr_o,
	output data_t   stData_o,
	// write-back and violation
	output logic    wbValid_o,
	output lsqIdx_t wbLqId_o,
	output data_t   wbData_o,
	output logic    vioValid_o,
	output lsqIdx_t vioLqId_o
);

	lsqPtrIf ptrIf ();

	memPkt_t memPkt;
	addr_t   srchAddr;		// ldq to stq lookup
	lsqIdx_t srchOlderTail;
	logic    fwdHit;		// stq answer
	data_t   fwdData;

	assign memPkt = '{valid: memValid_i, isLoad: memIsLoad_i, lsqId: memLsqId_i,
		addr: memAddr_i, data: memData_i};

	lsqControl #(.lsqDepth(lsqDepth)) control (
		.clk(clk), .reset(reset),
		.lsqValid_i(lsqValid_i), .lsqIsLoad_i(lsqIsLoad_i),
		.dispatchReady_i(dispatchReady_i),
		.commitLoad_i(commitLoad_i), .commitStore_i(commitStore_i),
		.recoverFlag_i(recoverFlag_i),
		.lsqId_o(lsqId_o), .ldqCount_o(ldqCount_o), .stqCount_o(stqCount_o),
		.ptr(ptrIf.ctrl)
	);

	storeQueue #(.lsqDepth(lsqDepth)) stq (
		.clk(clk), .reset(reset), .ptr(ptrIf.queue), .memPkt_i(memPkt),
		.srchAddr_i(srchAddr), .srchOlderTail_i(srchOlderTail),
		.fwdHit_o(fwdHit), .fwdData_o(fwdData),
		.stEn_o(stEn_o), .stAddr_o(stAddr_o), .stData_o(stData_o)
	);

	loadQueue #(.lsqDepth(lsqDepth)) ldq (
		.clk(clk), .reset(reset), .ptr(ptrIf.queue), .memPkt_i(memPkt),
		.srchAddr_o(srchAddr), .srchOlderTail_o(srchOlderTail),
		.fwdHit_i(fwdHit), .fwdData_i(fwdData),
		.ldEn_o(ldEn_o), .ldAddr_o(ldAddr_o), .ldData_i(ldData_i),
		.wbValid_o(wbValid_o), .wbLqId_o(wbLqId_o), .wbData_o(wbData_o),
		.vioValid_o(vioValid_o), .vioLqId_o(vioLqId_o)
	);

endmodule

// File: logic/storeQueue.sv
// store queue entries, store-to-load forwarding search and the commit write port to memory
`timescale 1ns/1ps

module storeQueue import lsuPkg::*; #(
	parameter int lsqDepth = LSQ_DEPTH
) (
	input  logic     clk,
	input  logic     reset,
	lsqPtrIf.queue   ptr,
	input  memPkt_t  memPkt_i,			// agen packet, only stores used here
	input  addr_t    srchAddr_i,		// load address to look up
	input  lsqIdx_t  srchOlderTail_i,	// stq tail the load saw at dispatch
	output logic     fwdHit_o,
	output data_t    fwdData_o,
	output logic     stEn_o,			// memory write strobe
	output addr_t    stAddr_o,
	output data_t    stData_o
);

	logic [lsqDepth-1:0] stValid;	// entry holds a dispatched store
	logic [lsqDepth-1:0] addrKnown;	// agen has delivered address and data
	addr_t               stAddr [lsqDepth];
	data_t               stData [lsqDepth];

	logic                stPkt;		// store packet this cycle
	logic [lsqDepth-1:0] olderMask;	// stores before the searching load
	logic [lsqDepth-1:0] matchVec;	// older, known and same word
	lsqIdx_t             fwdIdx;	// youngest matching entry

	assign stPkt = memPkt_i.valid & ~memPkt_i.isLoad;

	// entry state
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			stValid   <= '0;
			addrKnown <= '0;
		end
		else if (ptr.recover)
		begin
			stValid   <= '0;	// whole queue squashed
			addrKnown <= '0;
		end
		else
		begin
			if (ptr.commitSt)
			begin
				stValid[ptr.stqHead]   <= 1'b0;
				addrKnown[ptr.stqHead] <= 1'b0;
			end
			if (ptr.dispStore)
			begin
				stValid[ptr.stqTail]   <= 1'b1;
				addrKnown[ptr.stqTail] <= 1'b0;	// address comes later from agen
			end
			if (stPkt)
				addrKnown[memPkt_i.lsqId] <= 1'b1;
		end
	end

	// payload, written by agen
	always_ff @(posedge clk)
	begin
		if (stPkt)
		begin
			stAddr[memPkt_i.lsqId] <= memPkt_i.addr;
			stData[memPkt_i.lsqId] <= memPkt_i.data;
		end
	end

	// older window is head up to, not including, the load's recorded tail
	always_comb
	begin
		for (int i = 0; i < lsqDepth; i++)
		begin
			olderMask[i] = stValid[i] &&
				(ringDist(ptr.stqHead, lsqIdx_t'(i), lsqDepth) <
				 ringDist(ptr.stqHead, srchOlderTail_i, lsqDepth));
			matchVec[i] = olderMask[i] & addrKnown[i] & (stAddr[i] == srchAddr_i);
		end
	end

	// youngest hit is the one farthest from head
	always_comb
	begin
		fwdHit_o = 1'b0;
		fwdIdx   = '0;
		for (int i = 0; i < lsqDepth; i++)
		begin
			if (matchVec[i] && (!fwdHit_o ||
				ringDist(ptr.stqHead, lsqIdx_t'(i), lsqDepth) >
				ringDist(ptr.stqHead, fwdIdx, lsqDepth)))
			begin
				fwdHit_o = 1'b1;
				fwdIdx   = lsqIdx_t'(i);
			end
		end
	end

	assign fwdData_o = stData[fwdIdx];	// don't care when no hit

	// commit: head store goes out on the write port next cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			stEn_o <= 1'b0;
		else
			stEn_o <= ptr.commitSt;
	end

	always_ff @(posedge clk)
	begin
		if (ptr.commitSt)
		begin
			stAddr_o <= stAddr[ptr.stqHead];
			stData_o <= stData[ptr.stqHead];
		end
	end

endmodule

// File: sources.f
+incdir+verif
logic/lsuPkg.sv
logic/lsqPtrIf.sv
logic/lsqControl.sv
logic/storeQueue.sv
logic/loadQueue.sv
logic/lsuTop.sv
verif/lsuTb.sv

// File: verif/lsuTbModel.svh
// testbench memory, reference copy of both queues and the expected-result functions; included in the testbench module
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

localparam int MEM_WORDS = 64;

data_t memArr [MEM_WORDS];	// answers the DUT read port, written on stEn_o
data_t refMem [MEM_WORDS];	// model view, written when the model commits

// model entries, same indexing as the DUT
logic    mStValid [LSQ_DEPTH];
logic    mStKnown [LSQ_DEPTH];	// agen seen
addr_t   mStAddr [LSQ_DEPTH];
data_t   mStData [LSQ_DEPTH];
logic    mLdValid [LSQ_DEPTH];
logic    mLdExec [LSQ_DEPTH];
addr_t   mLdAddr [LSQ_DEPTH];
lsqIdx_t mLdRec [LSQ_DEPTH];	// stq tail at dispatch
lsqIdx_t mLdHead;
lsqIdx_t mLdTail;
lsqIdx_t mStHead;
lsqIdx_t mStTail;
int      mLdCnt;
int      mStCnt;

// start value of a word, distinct for every address
function automatic data_t fillWord(int a);
	return data_t'(32'h5A00_0000 + (a << 16) + a * 3 + 1);
endfunction

function automatic lsqIdx_t nextIdx(lsqIdx_t p);
	return lsqIdx_t'((int'(p) + 1) % LSQ_DEPTH);
endfunction

// walk from stq head towards rec, true if the store is passed on the way
function automatic bit storeBefore(lsqIdx_t stId, lsqIdx_t rec);
	lsqIdx_t p;
	p = mStHead;
	while (p != rec)
	begin
		if (p == stId)
			return 1'b1;
		p = nextIdx(p);
	end
	return 1'b0;
endfunction

// youngest older store with known matching address, else memory
function automatic data_t expLoadData(addr_t a, lsqIdx_t rec);
	data_t   d;
	lsqIdx_t p;
	d = refMem[int'(a) % MEM_WORDS];
	p = mStHead;
	while (p != rec)
	begin
		if (mStValid[p] && mStKnown[p] && mStAddr[p] == a)
			d = mStData[p];	// later hit is younger
		p = nextIdx(p);
	end
	return d;
endfunction

// oldest younger load that already read the word, -1 when none
function automatic int expViolation(lsqIdx_t stId, addr_t a);
	lsqIdx_t p;
	p = mLdHead;
	for (int n = 0; n < mLdCnt; n++)
	begin
		if (mLdValid[p] && mLdExec[p] && mLdAddr[p] == a && storeBefore(stId, mLdRec[p]))
			return int'(p);
		p = nextIdx(p);
	end
	return -1;
endfunction

// empty queues, pointers stay where they are
task automatic flushModel();
	for (int i = 0; i < LSQ_DEPTH; i++)
	begin
		mStValid[i] = 1'b0;
		mStKnown[i] = 1'b0;
		mLdValid[i] = 1'b0;
		mLdExec[i]  = 1'b0;
	end
	mLdTail = mLdHead;
	mStTail = mStHead;
	mLdCnt  = 0;
	mStCnt  = 0;
endtask

task automatic resetModel();
	for (int i = 0; i < MEM_WORDS; i++)
	begin
		memArr[i] = fillWord(i);
		refMem[i] = fillWord(i);
	end
	mLdHead = '0;
	mStHead = '0;
	flushModel();
endtask

`endif

// File: verif/lsuTb.sv
// testbench for the load-store unit; drives dispatch, agen, commit and recovery and checks against a queue model
`timescale 1ns/1ps

module lsuTb import lsuPkg::*; ();

	localparam int STIM_CYCLES = 150;	// reset plus the six tests, rounded up
	localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 100;
	localparam int SEED        = 99944;

	logic    clk;
	logic    reset;
	logic    lsqValid;
	logic    lsqIsLoad;
	logic    dispatchReady;
	logic    commitLoad;
	logic    commitStore;
	logic    recoverFlag;
	logic    memValid;
	logic    memIsLoad;
	lsqIdx_t memLsqId;
	addr_t   memAddr;
	data_t   memData;
	data_t   ldData;
	lsqIdx_t lsqId;
	lsqCnt_t ldqCount;
	lsqCnt_t stqCount;
	logic    ldEn;
	logic    stEn;
	logic    wbValid;
	logic    vioValid;
	addr_t   ldAddr;
	addr_t   stAddr;
	data_t   stData;
	data_t   wbData;
	lsqIdx_t wbLqId;
	lsqIdx_t vioLqId;

	`include "lsuTbModel.svh"

	// pending results with the cycle each is due
	int      wbDue [$];
	lsqIdx_t wbIdQ [$];
	data_t   wbDataQ [$];
	int      ldDue [$];
	addr_t   ldAddrQ [$];
	int      vioDue [$];
	lsqIdx_t vioIdQ [$];
	int      stDue [$];
	addr_t   stAddrQ [$];
	data_t   stDataQ [$];
	int      cycleCnt;
	bit      checkOn;	// set once reset is gone

	lsuTop #(.lsqDepth(LSQ_DEPTH)) UUT (
		.clk(clk), .reset(reset),
		.lsqValid_i(lsqValid), .lsqIsLoad_i(lsqIsLoad), .dispatchReady_i(dispatchReady),
		.lsqId_o(lsqId), .ldqCount_o(ldqCount), .stqCount_o(stqCount),
		.commitLoad_i(commitLoad), .commitStore_i(commitStore), .recoverFlag_i(recoverFlag),
		.memValid_i(memValid), .memIsLoad_i(memIsLoad), .memLsqId_i(memLsqId),
		.memAddr_i(memAddr), .memData_i(memData),
		.ldEn_o(ldEn), .ldAddr_o(ldAddr), .ldData_i(ldData),
		.stEn_o(stEn), .stAddr_o(stAddr), .stData_o(stData),
		.wbValid_o(wbValid), .wbLqId_o(wbLqId), .wbData_o(wbData),
		.vioValid_o(vioValid), .vioLqId_o(vioLqId)
	);

	always #20 clk = ~clk;	// 40 ns

	assign ldData = memArr[ldAddr[5:0]];	// async read

	always @(posedge clk)
	begin
		if (stEn)
			memArr[stAddr[5:0]] <= stData;
	end

	always @(posedge clk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= MAX_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			abortRun();
		end
	end

	task automatic abortRun();
		$display("Test failures found");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkIdx(string name, lsqIdx_t got, lsqIdx_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkCnt(string name, lsqCnt_t got, lsqCnt_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkAddr(string name, addr_t got, addr_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkData(string name, data_t got, data_t exp);
		if (got !== exp)
		begin
			$display("** Error at %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
			abortRun();
		end
	endtask

	// registered outputs checked on the falling edge every cycle
	always @(negedge clk)
	begin
		if (checkOn)
		begin
			if (ldDue.size() > 0 && ldDue[0] == cycleCnt)
			begin
				checkFlag("ldEn_o", ldEn, 1'b1);
				checkAddr("ldAddr_o", ldAddr, ldAddrQ.pop_front());
				void'(ldDue.pop_front());
			end
			else
				checkFlag("ldEn_o", ldEn, 1'b0);
			if (wbDue.size() > 0 && wbDue[0] == cycleCnt)
			begin
				checkFlag("wbValid_o", wbValid, 1'b1);
				checkIdx("wbLqId_o", wbLqId, wbIdQ.pop_front());
				checkData("wbData_o", wbData, wbDataQ.pop_front());
				void'(wbDue.pop_front());
			end
			else
				checkFlag("wbValid_o", wbValid, 1'b0);	// strobe stays low when nothing is due
			if (vioDue.size() > 0 && vioDue[0] == cycleCnt)
			begin
				checkFlag("vioValid_o", vioValid, 1'b1);
				checkIdx("vioLqId_o", vioLqId, vioIdQ.pop_front());
				void'(vioDue.pop_front());
			end
			else
				checkFlag("vioValid_o", vioValid, 1'b0);
			if (stDue.size() > 0 && stDue[0] == cycleCnt)
			begin
				checkFlag("stEn_o", stEn, 1'b1);
				checkAddr("stAddr_o", stAddr, stAddrQ.pop_front());
				checkData("stData_o", stData, stDataQ.pop_front());
				void'(stDue.pop_front());
			end
			else
				checkFlag("stEn_o", stEn, 1'b0);
		end
	end

	// wait a falling edge, check counts against the model and drop the strobes
	task automatic tick();
		@(negedge clk);
		checkCnt("ldqCount_o", ldqCount, lsqCnt_t'(mLdCnt));
		checkCnt("stqCount_o", stqCount, lsqCnt_t'(mStCnt));
		lsqValid      = 1'b0;
		dispatchReady = 1'b1;
		commitLoad    = 1'b0;
		commitStore   = 1'b0;
		recoverFlag   = 1'b0;
		memValid      = 1'b0;
	endtask

	task automatic idleCycles(int n);
		repeat (n)
			tick();
	endtask

	// ready low means the op is offered but not taken
	task automatic dispatchOp(input bit isLoad, input bit ready, output lsqIdx_t id);
		tick();
		lsqValid      = 1'b1;
		lsqIsLoad     = isLoad;
		dispatchReady = ready;
		id            = isLoad ? mLdTail : mStTail;
		#1;
		checkIdx("lsqId_o", lsqId, id);	// combinational in the same cycle
		if (ready && isLoad)
		begin
			mLdValid[id] = 1'b1;
			mLdExec[id]  = 1'b0;
			mLdRec[id]   = mStTail;
			mLdTail      = nextIdx(mLdTail);
			mLdCnt++;
		end
		else if (ready)
		begin
			mStValid[id] = 1'b1;
			mStKnown[id] = 1'b0;
			mStTail      = nextIdx(mStTail);
			mStCnt++;
		end
	endtask

	task automatic issueLoad(input lsqIdx_t id, input addr_t a);
		tick();
		memValid  = 1'b1;
		memIsLoad = 1'b1;
		memLsqId  = id;
		memAddr   = a;
		memData   = '0;
		ldDue.push_back(cycleCnt + 1);	// memory read at T+1
		ldAddrQ.push_back(a);
		wbDue.push_back(cycleCnt + 2);	// T+2
		wbIdQ.push_back(id);
		wbDataQ.push_back(expLoadData(a, mLdRec[id]));
		mLdExec[id] = 1'b1;
		mLdAddr[id] = a;
	endtask

	task automatic issueStore(input lsqIdx_t id, input addr_t a, input data_t d);
		int v;
		tick();
		memValid  = 1'b1;
		memIsLoad = 1'b0;
		memLsqId  = id;
		memAddr   = a;
		memData   = d;
		v = expViolation(id, a);
		if (v >= 0)
		begin
			vioDue.push_back(cycleCnt + 1);
			vioIdQ.push_back(lsqIdx_t'(v));
		end
		mStKnown[id] = 1'b1;
		mStAddr[id]  = a;
		mStData[id]  = d;
	endtask

	task automatic commitOldestStore();
		tick();
		commitStore = 1'b1;
		stDue.push_back(cycleCnt + 1);
		stAddrQ.push_back(mStAddr[mStHead]);
		stDataQ.push_back(mStData[mStHead]);
		refMem[int'(mStAddr[mStHead]) % MEM_WORDS] = mStData[mStHead];
		mStValid[mStHead] = 1'b0;
		mStHead = nextIdx(mStHead);
		mStCnt--;
	endtask

	task automatic commitOldestLoad();
		tick();
		commitLoad = 1'b1;
		mLdValid[mLdHead] = 1'b0;
		mLdHead = nextIdx(mLdHead);
		mLdCnt--;
	endtask

	// loads in flight past this cycle lose their write-back
	task automatic flushAll();
		tick();
		recoverFlag = 1'b1;
		flushModel();
		while (wbDue.size() > 0 && wbDue[wbDue.size() - 1] > cycleCnt)
		begin
			void'(wbDue.pop_back());
			void'(wbIdQ.pop_back());
			void'(wbDataQ.pop_back());
		end
	endtask

	task automatic drainQueues();
		while (mStCnt > 0)
			commitOldestStore();
		while (mLdCnt > 0)
			commitOldestLoad();
		idleCycles(3);	// let the last results come out
	endtask

	initial
	begin
		lsqIdx_t sA;
		lsqIdx_t sB;
		lsqIdx_t sC;
		lsqIdx_t sD;
		lsqIdx_t lA;
		lsqIdx_t lB;
		lsqIdx_t p;
		int      pick;
		int      seedVal;
		seedVal = SEED;
		seedVal = $urandom(seedVal);	// single seed for the run
		clk           = 1'b0;
		reset         = 1'b1;
		cycleCnt      = 0;
		checkOn       = 1'b0;
		lsqValid      = 1'b0;
		lsqIsLoad     = 1'b0;
		dispatchReady = 1'b0;
		commitLoad    = 1'b0;
		commitStore   = 1'b0;
		recoverFlag   = 1'b0;
		memValid      = 1'b0;
		memIsLoad     = 1'b0;
		memLsqId      = '0;
		memAddr       = '0;
		memData       = '0;
		resetModel();
		repeat (16)
			@(negedge clk);
		reset   = 1'b0;
		checkOn = 1'b1;

		// random mix where full queues fall back to another op
		for (int i = 0; i < 20; i++)
		begin
			pick = $urandom % 4;
			if (pick == 3 && mStCnt == LSQ_DEPTH)
				pick = 2;
			if (pick == 2 && mLdCnt == LSQ_DEPTH)
				pick = 0;
			if (pick == 0 && mLdCnt > 0)
				commitOldestLoad();
			else if (pick == 1)
				dispatchOp($urandom % 2, 1'b0, p);
			else if (pick == 3)
				dispatchOp(1'b0, 1'b1, p);
			else
				dispatchOp(1'b1, 1'b1, p);
		end
		p = mStHead;
		for (int n = 0; n < mStCnt; n++)
		begin
			issueStore(p, addr_t'(48 + $urandom % 16), $urandom);	// stores need an address to commit
			p = nextIdx(p);
		end
		drainQueues();

		// loads from memory
		dispatchOp(1'b1, 1'b1, lA);
		dispatchOp(1'b0, 1'b1, sA);
		dispatchOp(1'b1, 1'b1, lB);
		issueLoad(lA, 16'd5);
		issueStore(sA, 16'd9, 32'h1111_0009);
		issueLoad(lB, 16'd10);	// older store to another word
		drainQueues();

		// forwarding
		dispatchOp(1'b0, 1'b1, sA);
		dispatchOp(1'b0, 1'b1, sB);
		dispatchOp(1'b0, 1'b1, sC);	// address stays unknown for now
		dispatchOp(1'b1, 1'b1, lA);
		dispatchOp(1'b0, 1'b1, sD);	// younger than lA
		dispatchOp(1'b1, 1'b1, lB);
		issueStore(sA, 16'd20, 32'hAAAA_0001);
		issueStore(sB, 16'd20, 32'hBBBB_0002);
		issueStore(sD, 16'd20, 32'hDDDD_0004);
		issueLoad(lA, 16'd20);
		issueLoad(lB, 16'd20);
		issueStore(sC, 16'd20, 32'hCCCC_0003);	// late address catches lA
		drainQueues();

		// commit then read back
		dispatchOp(1'b0, 1'b1, sA);
		issueStore(sA, 16'd12, 32'h4444_000C);
		commitOldestStore();
		idleCycles(2);
		dispatchOp(1'b1, 1'b1, lA);
		issueLoad(lA, 16'd12);
		drainQueues();

		// violation where the oldest younger load wins
		dispatchOp(1'b0, 1'b1, sA);
		dispatchOp(1'b0, 1'b1, sB);
		dispatchOp(1'b1, 1'b1, lA);
		dispatchOp(1'b1, 1'b1, lB);
		issueLoad(lA, 16'd40);
		issueLoad(lB, 16'd40);
		idleCycles(1);
		issueStore(sB, 16'd41, 32'h5555_0041);	// no match
		issueStore(sA, 16'd40, 32'h5555_0040);
		drainQueues();

		// recovery
		dispatchOp(1'b0, 1'b1, sA);
		dispatchOp(1'b1, 1'b1, lA);
		dispatchOp(1'b1, 1'b1, lB);
		issueLoad(lA, 16'd3);
		issueLoad(lB, 16'd4);
		flushAll();	// lA already in wb stage and lB dropped
		idleCycles(3);
		dispatchOp(1'b1, 1'b1, lA);	// index is the head left by the flush
		dispatchOp(1'b0, 1'b1, sA);
		issueStore(sA, 16'd3, 32'h6666_0003);
		issueLoad(lA, 16'd3);
		drainQueues();

		$display("All tests passed!");
		$finish;
	end

endmodule
